/* Bender.yml */
package:
  name: l1_tag

sources:
  - src/l1_tag_pkg.sv
  - src/l1_tag_update_if.sv
  - src/sram_1r1w.sv
  - src/cache_valid_array.sv
  - src/l1_cache_tag.sv
  - src/l1_fill_ctrl.sv
  - src/l1_tag_top.sv
  - target: test
    files:
      - verif/l1_tag_tb.sv

/* flist.f */
src/l1_tag_pkg.sv
src/l1_tag_update_if.sv
src/sram_1r1w.sv
src/cache_valid_array.sv
src/l1_cache_tag.sv
src/l1_fill_ctrl.sv
src/l1_tag_top.sv
verif/l1_tag_tb.sv

/* src/cache_valid_array.sv */
// ####################################################################
// Valid bits for one cache way, one bit per set, kept in flip-flops.
// Reset marks every line invalid at once. The read is registered so
// it lines up with the tag RAM of the same way.
// ####################################################################

`default_nettype none
`timescale 1ns/100ps

module cache_valid_array #(
	parameter int NUM_SETS = 64
) (
	input wire clk,
	input wire reset,

	// Read port
	input wire rd_enable_i,
	input wire [$clog2(NUM_SETS)-1:0] rd_addr_i,
	output logic rd_is_valid_o,

	// Write port
	input wire wr_enable_i,
	input wire [$clog2(NUM_SETS)-1:0] wr_addr_i,
	input wire wr_is_valid_i
);

	logic [NUM_SETS-1:0] valid_bits;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			rd_is_valid_o <= 1'b0;
		end
		else
		begin
			// Nonblocking update, so a read of the same set
			// at this edge still sees the old bit
			if (wr_enable_i)
				valid_bits[wr_addr_i] <= wr_is_valid_i;

			// Hold the last read value when idle
			if (rd_enable_i)
				rd_is_valid_o <= valid_bits[rd_addr_i];
		end
	end

endmodule

`default_nettype wire

/* src/l1_cache_tag.sv */
// ####################################################################
// Tag and valid storage of a four-way L1 data cache with hit lookup.
// A lookup issued with access_i gives cache_hit_o and hit_way_o in
// the next cycle. Updates arrive as one command per cycle from the
// fill controller through the update interface.
// ####################################################################

`default_nettype none
`timescale 1ns/100ps

module l1_cache_tag #(
	parameter int NUM_SETS = 64
) (
	input wire clk,
	input wire reset,

	// Lookup request
	input wire access_i,
	input wire [l1_tag_pkg::ADDR_WIDTH-1:0] request_addr_i,

	// Update command from the fill controller
	l1_tag_update_if.tag update,

	// Lookup result, one cycle after the request
	output logic cache_hit_o,
	output l1_tag_pkg::way_t hit_way_o,
	output logic [$clog2(NUM_SETS)-1:0] hit_set_o
);

	import l1_tag_pkg::*;

	localparam int NUM_WAYS = 4;
	localparam int SET_WIDTH = $clog2(NUM_SETS);
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH;

	logic [SET_WIDTH-1:0] request_set;
	logic [TAG_WIDTH-1:0] request_tag;

	// Lookup state carried into the compare cycle
	logic access_latched;
	logic [TAG_WIDTH-1:0] tag_latched;
	logic [SET_WIDTH-1:0] set_latched;

	// Per-way write decode
	logic targets_one_way;
	logic wr_valid;
	logic [NUM_WAYS-1:0] way_wr_en;

	// Per-way read results and compare outcome
	logic [TAG_WIDTH-1:0] way_tag [NUM_WAYS];
	logic [NUM_WAYS-1:0] way_valid;
	logic [NUM_WAYS-1:0] way_hit;

	// Set index sits in the low bits of the line address
	assign request_set = request_addr_i[SET_WIDTH-1:0];
	assign request_tag = request_addr_i[ADDR_WIDTH-1:SET_WIDTH];

	// Fill and single invalidate both address one way
	assign targets_one_way = (update.op == OP_FILL) || (update.op == OP_INVAL_ONE);

	// Only a fill leaves the line valid
	assign wr_valid = (update.op == OP_FILL);

	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : gen_way
		// A whole-set invalidate hits every way
		assign way_wr_en[w] = (update.op == OP_INVAL_ALL)
			|| (targets_one_way && update.way == way_t'(w));

		// Tag RAM is only written on a fill, invalidates just drop valid
		sram_1r1w #(
			.DATA_WIDTH(TAG_WIDTH),
			.SIZE(NUM_SETS)
		) tag_mem (
			.clk(clk),
			.reset(reset),
			.rd_enable_i(access_i),
			.rd_addr_i(request_set),
			.rd_data_o(way_tag[w]),
			.wr_enable_i(way_wr_en[w] && wr_valid),
			.wr_addr_i(update.set),
			.wr_data_i(update.wr_tag)
		);

		cache_valid_array #(
			.NUM_SETS(NUM_SETS)
		) valid_mem (
			.clk(clk),
			.reset(reset),
			.rd_enable_i(access_i),
			.rd_addr_i(request_set),
			.rd_is_valid_o(way_valid[w]),
			.wr_enable_i(way_wr_en[w]),
			.wr_addr_i(update.set),
			.wr_is_valid_i(wr_valid)
		);

		// Compare against the tag of the request being resolved
		assign way_hit[w] = way_valid[w] && (way_tag[w] == tag_latched);
	end

	// The access strobe is control state and resets
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			access_latched <= 1'b0;
		else
			access_latched <= access_i;
	end

	// Tag and set of the request only matter while access_latched is high
	always_ff @(posedge clk)
	begin
		tag_latched <= request_tag;
		set_latched <= request_set;
	end

	// One-hot to index, at most one way can match for a given tag
	assign hit_way_o = {way_hit[2] | way_hit[3], way_hit[1] | way_hit[3]};

	// The RAM outputs hold stale data after an idle cycle, so qualify
	assign cache_hit_o = (|way_hit) && access_latched;

	assign hit_set_o = set_latched;

endmodule

`default_nettype wire

/* src/l1_fill_ctrl.sv */
// ####################################################################
// Replacement and update control for the four-way tag array.
// Keeps a three-bit pseudo-LRU tree per set, picks the victim of a
// fill, and merges invalidates and fills into one update command.
// ####################################################################

`default_nettype none
`timescale 1ns/100ps

module l1_fill_ctrl #(
	parameter int NUM_SETS = 64
) (
	input wire clk,
	input wire reset,

	// Fill and invalidate requests
	input wire fill_i,
	input wire [l1_tag_pkg::ADDR_WIDTH-1:0] fill_addr_i,
	input wire inval_i,
	input wire inval_all_i,
	input wire [$clog2(NUM_SETS)-1:0] inval_set_i,
	input wire l1_tag_pkg::way_t inval_way_i,

	// Lookup result from the tag block
	input wire cache_hit_i,
	input wire l1_tag_pkg::way_t hit_way_i,
	input wire [$clog2(NUM_SETS)-1:0] hit_set_i,

	l1_tag_update_if.ctrl update,

	output logic fill_done_o,
	output l1_tag_pkg::way_t fill_way_o
);

	import l1_tag_pkg::*;

	localparam int SET_WIDTH = $clog2(NUM_SETS);

	// Tree bits per set, [0] picks the half, [1] and [2] pick within it
	logic [2:0] plru_bits [NUM_SETS];

	logic [SET_WIDTH-1:0] fill_set;
	logic [2:0] fill_plru;
	way_t victim_way;
	logic fill_go;

	// Hit registered for one cycle before it touches the tree
	logic hit_pending;
	way_t hit_way_q;
	logic [SET_WIDTH-1:0] hit_set_q;

	// Point the tree away from the way that was just used
	function automatic logic [2:0] plru_touch(input logic [2:0] bits, input way_t w);
		logic [2:0] next_bits;
		next_bits = bits;
		next_bits[0] = ~w[1];
		if (w[1])
			next_bits[2] = ~w[0];
		else
			next_bits[1] = ~w[0];
		return next_bits;
	endfunction

	assign fill_set = fill_addr_i[SET_WIDTH-1:0];
	assign fill_plru = plru_bits[fill_set];
	assign victim_way = fill_plru[0] ? {1'b1, fill_plru[2]} : {1'b0, fill_plru[1]};

	// Invalidates take priority, a losing fill is simply dropped
	assign fill_go = fill_i && !inval_i && !inval_all_i;

	always_comb
	begin
		update.op = OP_NONE;
		update.way = victim_way;
		update.wr_tag = fill_addr_i[ADDR_WIDTH-1:SET_WIDTH];
		update.set = fill_set;
		if (inval_all_i)
		begin
			update.op = OP_INVAL_ALL;
			update.set = inval_set_i;
		end
		else if (inval_i)
		begin
			update.op = OP_INVAL_ONE;
			update.way = inval_way_i;
			update.set = inval_set_i;
		end
		else if (fill_i)
			update.op = OP_FILL;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				plru_bits[s] <= 3'b000;
			hit_pending <= 1'b0;
			fill_done_o <= 1'b0;
		end
		else
		begin
			hit_pending <= cache_hit_i;
			fill_done_o <= fill_go;
			// When both land on one set the fill's update is kept
			if (hit_pending && !(fill_go && hit_set_q == fill_set))
				plru_bits[hit_set_q] <= plru_touch(plru_bits[hit_set_q], hit_way_q);
			if (fill_go)
				plru_bits[fill_set] <= plru_touch(fill_plru, victim_way);
		end
	end

	always_ff @(posedge clk)
	begin
		hit_way_q <= hit_way_i;
		hit_set_q <= hit_set_i;
		fill_way_o <= victim_way;
	end

endmodule

`default_nettype wire

/* src/l1_tag_pkg.sv */
// ####################################################################
// Shared definitions for the L1 data cache tag path.
// Holds the line address width, the way index type and the opcodes
// of the tag array update command. Modules import what they need.
// ####################################################################

`default_nettype none

package l1_tag_pkg;

	// Width of a line address, with the set index in the low bits
	localparam int ADDR_WIDTH = 26;

	// Index of one of the four ways of a set
	typedef logic [1:0] way_t;

	// Commands that can be applied to the tag array in one cycle
	typedef enum logic [1:0]
	{
		// Nothing is written this cycle
		OP_NONE = 2'd0,
		// Write the tag into one way and mark it valid
		OP_FILL = 2'd1,
		// Clear the valid bit of a single way
		OP_INVAL_ONE = 2'd2,
		// Clear the valid bits of every way in the set
		OP_INVAL_ALL = 2'd3
	} update_op_e;

endpackage

`default_nettype wire

/* src/l1_tag_top.sv */
// ####################################################################
// Top level of the L1 data cache tag path.
// Joins the tag lookup block and the fill controller over the update
// interface and exposes lookup, fill and invalidate as plain ports.
// ####################################################################

`default_nettype none
`timescale 1ns/100ps

module l1_tag_top #(
	parameter int NUM_SETS = 64
) (
	input wire clk,
	input wire reset,

	// Lookup
	input wire access_i,
	input wire [l1_tag_pkg::ADDR_WIDTH-1:0] request_addr_i,
	output logic cache_hit_o,
	output l1_tag_pkg::way_t hit_way_o,

	// Fill from the level-2 side
	input wire fill_i,
	input wire [l1_tag_pkg::ADDR_WIDTH-1:0] fill_addr_i,
	output logic fill_done_o,
	output l1_tag_pkg::way_t fill_way_o,

	// Invalidate one way or a whole set
	input wire inval_i,
	input wire inval_all_i,
	input wire [$clog2(NUM_SETS)-1:0] inval_set_i,
	input wire l1_tag_pkg::way_t inval_way_i
);

	// Set of the lookup that produced the current hit
	logic [$clog2(NUM_SETS)-1:0] hit_set;

	// Update command from the controller to the tag block
	l1_tag_update_if #(
		.NUM_SETS(NUM_SETS)
	) update_bus ();

	l1_cache_tag #(
		.NUM_SETS(NUM_SETS)
	) tag_i (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.request_addr_i(request_addr_i),
		.update(update_bus.tag),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way_o),
		.hit_set_o(hit_set)
	);

	// Hits are fed back so the controller can age the pseudo-LRU tree
	l1_fill_ctrl #(
		.NUM_SETS(NUM_SETS)
	) fill_ctrl_i (
		.clk(clk),
		.reset(reset),
		.fill_i(fill_i),
		.fill_addr_i(fill_addr_i),
		.inval_i(inval_i),
		.inval_all_i(inval_all_i),
		.inval_set_i(inval_set_i),
		.inval_way_i(inval_way_i),
		.cache_hit_i(cache_hit_o),
		.hit_way_i(hit_way_o),
		.hit_set_i(hit_set),
		.update(update_bus.ctrl),
		.fill_done_o(fill_done_o),
		.fill_way_o(fill_way_o)
	);

endmodule

`default_nettype wire

/* src/l1_tag_update_if.sv */
// ####################################################################
// One tag array update command, driven by the fill controller and
// applied by the tag block at the clock edge where it is presented.
// ####################################################################

`default_nettype none
`timescale 1ns/100ps

interface l1_tag_update_if #(
	parameter int NUM_SETS = 64
);
	import l1_tag_pkg::*;

	localparam int SET_WIDTH = $clog2(NUM_SETS);
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH;

	// What to do this cycle
	update_op_e op;
	// Target way, ignored for a whole-set invalidate
	way_t way;
	// Tag written on a fill
	logic [TAG_WIDTH-1:0] wr_tag;
	logic [SET_WIDTH-1:0] set;

	// The fill controller builds the command
	modport ctrl (output op, output way, output wr_tag, output set);
	// The tag block consumes it
	modport tag (input op, input way, input wr_tag, input set);

endinterface

`default_nettype wire

/* src/sram_1r1w.sv */
// ####################################################################
// Generic RAM with one read port and one write port.
// The read is registered and returns the old contents when the same
// entry is written at the same edge.
// ####################################################################

`default_nettype none
`timescale 1ns/100ps

module sram_1r1w #(
	parameter int DATA_WIDTH = 32,
	parameter int SIZE = 64
) (
	input wire clk,
	input wire reset,

	// Read port
	input wire rd_enable_i,
	input wire [$clog2(SIZE)-1:0] rd_addr_i,
	output logic [DATA_WIDTH-1:0] rd_data_o,

	// Write port
	input wire wr_enable_i,
	input wire [$clog2(SIZE)-1:0] wr_addr_i,
	input wire [DATA_WIDTH-1:0] wr_data_i
);

	// Storage itself has no reset
	logic [DATA_WIDTH-1:0] mem [SIZE];

	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// Output register keeps its value on cycles with no read
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rd_data_o <= '0;
		else if (rd_enable_i)
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

/* verif/l1_tag_tb.sv */
// ####################################################################
// Self-checking testbench for the L1 data cache tag path.
// Applies a table of lookups, fills and invalidates to the top level
// and checks the results against a model of tags, valid bits and the
// pseudo-LRU trees. Run it as the simulation top.
// ####################################################################

`default_nettype none
`timescale 1ns/100ps

module l1_tag_tb;

	import l1_tag_pkg::*;

	localparam int NUM_SETS = 64;
	localparam int SW = $clog2(NUM_SETS);
	localparam int TW = ADDR_WIDTH - SW;
	localparam int DONE_TIMEOUT = 20;
	localparam int STREAM_LEN = 32;
	localparam int NUM_ROWS = 31;

	// What one table row does to the DUT
	typedef enum logic [2:0]
	{
		K_LOOK, K_FILL, K_INV1, K_INVA, K_CONFLICT, K_HITFILL, K_STREAM
	} kind_e;

	// The way field is the expected way for lookups and fills, the target way for invalidates
	typedef struct packed
	{
		kind_e kind;
		logic [SW-1:0] set;
		logic [TW-1:0] tag;
		logic [TW-1:0] ftag;
		way_t way;
		logic exp_hit;
		logic model;
	} row_t;

	logic clk, reset;
	logic access_i, fill_i, inval_i, inval_all_i;
	logic [ADDR_WIDTH-1:0] request_addr_i, fill_addr_i;
	logic [SW-1:0] inval_set_i;
	way_t inval_way_i, hit_way_o, fill_way_o;
	logic cache_hit_o, fill_done_o;

	row_t rows [NUM_ROWS];
	logic [31:0] rng;
	int errors, passed, failed;
	logic row_fail, timed_out;

	// Reference state, kept in step with every command applied
	logic [TW-1:0] m_tag [NUM_SETS][4];
	logic [3:0] m_valid [NUM_SETS];
	logic [2:0] m_plru [NUM_SETS];

	l1_tag_top #(.NUM_SETS(NUM_SETS)) dut_i (
		.clk(clk), .reset(reset),
		.access_i(access_i), .request_addr_i(request_addr_i),
		.cache_hit_o(cache_hit_o), .hit_way_o(hit_way_o),
		.fill_i(fill_i), .fill_addr_i(fill_addr_i),
		.fill_done_o(fill_done_o), .fill_way_o(fill_way_o),
		.inval_i(inval_i), .inval_all_i(inval_all_i),
		.inval_set_i(inval_set_i), .inval_way_i(inval_way_i)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// b0 picks the half, then b1 or b2 picks the way inside it
	function automatic way_t plru_victim(input logic [2:0] b);
		way_t v;
		v[1] = b[0];
		v[0] = b[0] ? b[2] : b[1];
		return v;
	endfunction

	// Using a way points every tree bit on its path away from it
	function automatic logic [2:0] plru_after_use(input logic [2:0] b, input way_t w);
		logic [2:0] n;
		n = b;
		n[0] = !w[1];
		n[1 + w[1]] = !w[0];
		return n;
	endfunction

	task automatic model_lookup(input logic [SW-1:0] s, input logic [TW-1:0] t,
		output logic hit, output way_t w);
		hit = 1'b0;
		w = '0;
		for (int i = 0; i < 4; i++)
			if (m_valid[s][i] && m_tag[s][i] == t)
			begin
				hit = 1'b1;
				w = way_t'(i);
			end
		if (hit)
			m_plru[s] = plru_after_use(m_plru[s], w);
	endtask

	task automatic model_fill(input logic [SW-1:0] s, input logic [TW-1:0] t, output way_t v);
		v = plru_victim(m_plru[s]);
		m_tag[s][v] = t;
		m_valid[s][v] = 1'b1;
		m_plru[s] = plru_after_use(m_plru[s], v);
	endtask

	task automatic check_hit(input logic exp_hit, input way_t exp_way, input string what);
		if (cache_hit_o !== exp_hit || (exp_hit && hit_way_o !== exp_way))
		begin
			$display("ERR %0t ns: %s gave hit %b way %0d, expected hit %b way %0d",
				$time, what, cache_hit_o, hit_way_o, exp_hit, exp_way);
			errors++;
			row_fail = 1'b1;
		end
	endtask

	task automatic check_fill(input logic exp_done, input way_t exp_way, input string what);
		if (fill_done_o !== exp_done || (exp_done && fill_way_o !== exp_way))
		begin
			$display("ERR %0t ns: %s gave done %b way %0d, expected done %b way %0d",
				$time, what, fill_done_o, fill_way_o, exp_done, exp_way);
			errors++;
			row_fail = 1'b1;
		end
	endtask

	// A one-cycle lookup is checked in the cycle after and followed by one idle
	// cycle, so the hit has reached the pseudo-LRU before the next row
	task automatic do_lookup(input logic [SW-1:0] s, input logic [TW-1:0] t,
		input logic exp_hit, input way_t exp_way);
		@(posedge clk);
		access_i <= 1'b1;
		request_addr_i <= {t, s};
		@(posedge clk);
		access_i <= 1'b0;
		@(negedge clk);
		check_hit(exp_hit, exp_way, "lookup");
		@(posedge clk);
	endtask

	task automatic wait_fill_done(input way_t exp_way);
		int n;
		n = 0;
		@(negedge clk);
		while (!fill_done_o && n < DONE_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!fill_done_o)
		begin
			$display("Timeout: fill_done_o did not rise within %0d cycles", DONE_TIMEOUT);
			timed_out = 1'b1;
		end
		else
		begin
			check_fill(1'b1, exp_way, "fill");
			// The completion pulse lasts exactly one cycle
			@(negedge clk);
			check_fill(1'b0, exp_way, "fill pulse end");
		end
	endtask

	task automatic do_fill(input logic [SW-1:0] s, input logic [TW-1:0] t, input way_t exp_way);
		@(posedge clk);
		fill_i <= 1'b1;
		fill_addr_i <= {t, s};
		@(posedge clk);
		fill_i <= 1'b0;
		wait_fill_done(exp_way);
	endtask

	task automatic do_inval(input logic all, input logic [SW-1:0] s, input way_t w);
		@(posedge clk);
		inval_i <= !all;
		inval_all_i <= all;
		inval_set_i <= s;
		inval_way_i <= w;
		@(posedge clk);
		inval_i <= 1'b0;
		inval_all_i <= 1'b0;
		if (all)
			m_valid[s] = 4'b0000;
		else
			m_valid[s][w] = 1'b0;
	endtask

	// Prefill sets 16 to 19, then issue a lookup every cycle with random fills
	// to sets 32 to 63, checking each result one cycle after its issue
	task automatic run_stream();
		logic [SW-1:0] s;
		logic [TW-1:0] t;
		logic cur_hit, cur_fill, prev_hit, prev_fill;
		way_t cur_way, cur_vic, prev_way, prev_vic;
		cur_hit = 1'b0;
		cur_way = '0;
		cur_vic = '0;
		for (int j = 0; j < 16 && !timed_out; j++)
		begin
			rng = xorshift(rng);
			s = SW'(16 + j % 4);
			model_fill(s, rng[31:12], cur_vic);
			do_fill(s, rng[31:12], cur_vic);
		end
		for (int i = 0; i <= STREAM_LEN && !timed_out; i++)
		begin
			@(posedge clk);
			cur_fill = 1'b0;
			access_i <= 1'b0;
			fill_i <= 1'b0;
			if (i < STREAM_LEN)
			begin
				rng = xorshift(rng);
				s = SW'(16 + rng[1:0]);
				t = rng[2] ? m_tag[s][rng[4:3]] : rng[31:12];
				model_lookup(s, t, cur_hit, cur_way);
				access_i <= 1'b1;
				request_addr_i <= {t, s};
				cur_fill = rng[5];
				if (cur_fill)
				begin
					rng = xorshift(rng);
					s = SW'(32 + rng[4:0]);
					model_fill(s, rng[31:12], cur_vic);
					fill_i <= 1'b1;
					fill_addr_i <= {rng[31:12], s};
				end
			end
			@(negedge clk);
			if (i > 0)
			begin
				check_hit(prev_hit, prev_way, "stream lookup");
				check_fill(prev_fill, prev_vic, "stream fill");
			end
			prev_hit = cur_hit;
			prev_way = cur_way;
			prev_fill = cur_fill && (i < STREAM_LEN);
			prev_vic = cur_vic;
		end
	endtask

	task automatic run_row(input row_t r);
		logic mh;
		way_t mw, v;
		logic [2:0] saved;
		case (r.kind)
			K_LOOK:
			begin
				model_lookup(r.set, r.tag, mh, mw);
				do_lookup(r.set, r.tag, r.model ? mh : r.exp_hit, r.model ? mw : r.way);
			end
			K_FILL:
			begin
				model_fill(r.set, r.tag, v);
				do_fill(r.set, r.tag, r.model ? v : r.way);
			end
			K_INV1: do_inval(1'b0, r.set, r.way);
			K_INVA: do_inval(1'b1, r.set, r.way);
			K_CONFLICT:
			begin
				// A fill and an invalidate share one edge and the fill must vanish
				@(posedge clk);
				fill_i <= 1'b1;
				fill_addr_i <= {r.ftag, r.set};
				inval_i <= 1'b1;
				inval_set_i <= r.set;
				inval_way_i <= r.way;
				@(posedge clk);
				fill_i <= 1'b0;
				inval_i <= 1'b0;
				m_valid[r.set][r.way] = 1'b0;
				repeat (4)
				begin
					@(negedge clk);
					check_fill(1'b0, '0, "dropped fill");
				end
			end
			K_HITFILL:
			begin
				// The fill lands on the edge where the hit would age the tree
				saved = m_plru[r.set];
				model_lookup(r.set, r.tag, mh, mw);
				m_plru[r.set] = saved;
				model_fill(r.set, r.ftag, v);
				@(posedge clk);
				access_i <= 1'b1;
				request_addr_i <= {r.tag, r.set};
				@(posedge clk);
				access_i <= 1'b0;
				@(negedge clk);
				check_hit(mh, mw, "lookup before fill");
				@(posedge clk);
				fill_i <= 1'b1;
				fill_addr_i <= {r.ftag, r.set};
				@(posedge clk);
				fill_i <= 1'b0;
				wait_fill_done(v);
			end
			default: run_stream();
		endcase
	endtask

	task automatic load_table();
		rows[0] = '{K_LOOK, 6'd5, 20'h00111, 20'h0, 2'd0, 1'b0, 1'b0};
		rows[1] = '{K_LOOK, 6'd40, 20'h00222, 20'h0, 2'd0, 1'b0, 1'b0};
		// Victims from a cleared tree come out as 0, 2, 1, 3
		rows[2] = '{K_FILL, 6'd5, 20'h000a0, 20'h0, 2'd0, 1'b0, 1'b0};
		rows[3] = '{K_FILL, 6'd5, 20'h000a1, 20'h0, 2'd2, 1'b0, 1'b0};
		rows[4] = '{K_FILL, 6'd5, 20'h000a2, 20'h0, 2'd1, 1'b0, 1'b0};
		rows[5] = '{K_FILL, 6'd5, 20'h000a3, 20'h0, 2'd3, 1'b0, 1'b0};
		rows[6] = '{K_LOOK, 6'd5, 20'h000a0, 20'h0, 2'd0, 1'b1, 1'b0};
		rows[7] = '{K_LOOK, 6'd5, 20'h000a1, 20'h0, 2'd2, 1'b1, 1'b0};
		rows[8] = '{K_LOOK, 6'd5, 20'h000a2, 20'h0, 2'd1, 1'b1, 1'b0};
		rows[9] = '{K_LOOK, 6'd5, 20'h000a3, 20'h0, 2'd3, 1'b1, 1'b0};
		// A hit on way 1 moves the next victim to way 2
		rows[10] = '{K_LOOK, 6'd5, 20'h000a2, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[11] = '{K_FILL, 6'd5, 20'h000a4, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[12] = '{K_LOOK, 6'd5, 20'h000a1, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[13] = '{K_LOOK, 6'd5, 20'h000a4, 20'h0, 2'd0, 1'b0, 1'b1};
		// The hit on way 2 and the fill of way 0 would leave different trees
		rows[14] = '{K_HITFILL, 6'd5, 20'h000a4, 20'h000a5, 2'd0, 1'b0, 1'b1};
		rows[15] = '{K_FILL, 6'd5, 20'h000a6, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[16] = '{K_INV1, 6'd5, 20'h0, 20'h0, 2'd1, 1'b0, 1'b0};
		rows[17] = '{K_LOOK, 6'd5, 20'h000a2, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[18] = '{K_LOOK, 6'd5, 20'h000a4, 20'h0, 2'd0, 1'b0, 1'b1};
		// Refill the emptied way so the whole-set invalidate sees four valid lines
		rows[19] = '{K_FILL, 6'd5, 20'h000a7, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[20] = '{K_FILL, 6'd9, 20'h000b0, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[21] = '{K_INVA, 6'd5, 20'h0, 20'h0, 2'd0, 1'b0, 1'b0};
		rows[22] = '{K_LOOK, 6'd5, 20'h000a5, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[23] = '{K_LOOK, 6'd5, 20'h000a4, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[24] = '{K_LOOK, 6'd5, 20'h000a6, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[25] = '{K_LOOK, 6'd5, 20'h000a7, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[26] = '{K_LOOK, 6'd9, 20'h000b0, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[27] = '{K_CONFLICT, 6'd9, 20'h0, 20'h000c0, 2'd0, 1'b0, 1'b1};
		rows[28] = '{K_LOOK, 6'd9, 20'h000c0, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[29] = '{K_LOOK, 6'd9, 20'h000b0, 20'h0, 2'd0, 1'b0, 1'b1};
		rows[30] = '{K_STREAM, 6'd0, 20'h0, 20'h0, 2'd0, 1'b0, 1'b1};
	endtask

	initial
	begin
		kind_e k;
		clk = 1'b0;
		reset = 1'b1;
		access_i = 1'b0;
		request_addr_i = '0;
		fill_i = 1'b0;
		fill_addr_i = '0;
		inval_i = 1'b0;
		inval_all_i = 1'b0;
		inval_set_i = '0;
		inval_way_i = '0;
		rng = 32'ha732;
		errors = 0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		for (int s = 0; s < NUM_SETS; s++)
		begin
			m_valid[s] = 4'b0000;
			m_plru[s] = 3'b000;
		end
		load_table();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < NUM_ROWS && !timed_out; i++)
		begin
			row_fail = 1'b0;
			k = rows[i].kind;
			run_row(rows[i]);
			if (row_fail || timed_out)
				failed++;
			else
				passed++;
			$display("test %0d %s %s", i, k.name(), (row_fail || timed_out) ? "failed" : "ok");
		end
		$display("Tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
		if (errors == 0 && !timed_out)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
